// ==== tb.f ====
source/oldland_isa_pkg.sv
source/oldland_pipe_pkg.sv
source/oldland_fetch.sv
source/oldland_decode.sv
source/oldland_regfile.sv
source/oldland_exec.sv
source/oldland_lsu.sv
source/oldland_cpu.sv
sim/tb_mem.sv
sim/tb_oldland.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -sv
TOP       := tb_oldland
FILELIST  := tb.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_oldland.sv ====
module tb_oldland;
	import oldland_isa_pkg::*;
	import oldland_pipe_pkg::*;

	localparam int num_tests = 6;
	localparam int max_instr = 200;
	// cycles allowed for one program to reach halt
	localparam int run_limit = max_instr * 40;
	localparam logic [31:0] data_base = 32'h2000;
	localparam logic [31:0] marker = 32'h600d0b0e;

	logic clk;
	logic reset;
	logic fill;
	logic load_en;
	logic [11:0] load_addr;
	logic [31:0] load_data;
	logic halted;
	axil_rd_req_t imem_req;
	axil_rd_rsp_t imem_rsp;
	axil_rd_req_t dmem_rd_req;
	axil_rd_rsp_t dmem_rd_rsp;
	axil_wr_req_t dmem_wr_req;
	axil_wr_rsp_t dmem_wr_rsp;
	logic [31:0] lfsr;
	logic [31:0] prog [$];

	oldland_cpu dut (
		.clk, .reset, .imem_rsp, .dmem_rd_rsp, .dmem_wr_rsp,
		.imem_req, .dmem_rd_req, .dmem_wr_req, .halted
	);

	tb_mem mem (
		.clk, .reset, .fill, .load_en, .load_addr, .load_data,
		.imem_req, .dmem_rd_req, .dmem_wr_req,
		.imem_rsp, .dmem_rd_rsp, .dmem_wr_rsp
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'ha3000000 : 32'h0);
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [31:0] arith(input logic [3:0] opc, input logic [2:0] rd,
			input logic [2:0] ra, input logic [2:0] rb, input logic [15:0] imm,
			input logic use_rb);
		logic [31:0] w;
		w = '0;
		w[class_msb:class_lsb] = class_arith;
		w[opc_msb:opc_lsb] = opc;
		w[imm16_msb:imm16_lsb] = imm;
		w[op2_rb_bit] = use_rb;
		w[rd_msb:rd_lsb] = rd;
		w[ra_msb:ra_lsb] = ra;
		w[rb_msb:rb_lsb] = rb;
		return w;
	endfunction

	// r0 stays zero so the immediate is the whole address
	function automatic logic [31:0] mem_op(input logic store, input logic [2:0] rd,
			input logic [2:0] rb, input logic [31:0] addr);
		logic [31:0] w;
		w = '0;
		w[class_msb:class_lsb] = class_mem;
		w[store_bit] = store;
		w[imm16_msb:imm16_lsb] = addr[15:0];
		w[rd_msb:rd_lsb] = rd;
		w[rb_msb:rb_lsb] = rb;
		return w;
	endfunction

	function automatic logic [31:0] branch(input logic [2:0] cond, input logic by_reg,
			input logic [2:0] ra, input logic [23:0] off);
		logic [31:0] w;
		w = '0;
		w[class_msb:class_lsb] = class_branch;
		w[cond_msb:cond_lsb] = cond;
		w[imm24_msb:imm24_lsb] = off;
		w[branch_ra_bit] = by_reg;
		if (by_reg)
			w[ra_msb:ra_lsb] = ra;
		return w;
	endfunction

	function automatic logic [31:0] halt_word();
		logic [31:0] w;
		w = '0;
		w[class_msb:class_lsb] = class_misc;
		w[opc_msb:opc_lsb] = misc_halt;
		return w;
	endfunction

	// result of one arithmetic opcode by the instruction set rules
	function automatic logic [31:0] alu_ref(input logic [3:0] opc, input logic [31:0] a,
			input logic [31:0] b);
		case (opc)
		opc_add: return a + b;
		opc_sub: return a - b;
		opc_and: return a & b;
		opc_or: return a | b;
		opc_xor: return a ^ b;
		opc_lsl: return a << b[4:0];
		opc_lsr: return a >> b[4:0];
		opc_asr: return $unsigned($signed(a) >>> b[4:0]);
		default: return 32'hx;
		endcase
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {16'ha5a5, addr[15:0]};
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return mem.words[addr[13:2]];
	endfunction

	task automatic put(input logic [31:0] w);
		prog.push_back(w);
	endtask

	// full 32-bit constant with r7 as scratch for the zero extended low half
	task automatic load_const(input logic [2:0] rd, input logic [31:0] val);
		put(arith(opc_movhi, rd, 0, 0, val[31:16], 0));
		put(arith(opc_mov, 7, 0, 0, val[15:0], 0));
		put(arith(opc_lsl, 7, 7, 0, 16, 0));
		put(arith(opc_lsr, 7, 7, 0, 16, 0));
		put(arith(opc_or, rd, rd, 7, 0, 1));
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// reset held while memory is filled and the program loaded
	task automatic start_program();
		reset = 1'b1;
		@(posedge clk);
		#1 fill = 1'b1;
		@(posedge clk);
		#1 fill = 1'b0;
		foreach (prog[i]) begin
			load_en = 1'b1;
			load_addr = 12'(i);
			load_data = prog[i];
			@(posedge clk);
			#1;
		end
		load_en = 1'b0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
	endtask

	task automatic run_program(input string name);
		int cycles;
		start_program();
		cycles = 0;
		while (!halted) begin
			if (cycles == run_limit) begin
				$display("%s: core did not halt within %0d cycles", name, run_limit);
				$display("sim failed");
				$fatal(1);
			end
			@(posedge clk);
			#1;
			cycles++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic test_arith();
		logic [31:0] a;
		logic [31:0] b;
		logic [3:0] ops [8] = '{opc_add, opc_sub, opc_and, opc_or,
			opc_xor, opc_lsl, opc_lsr, opc_asr};
		prog.delete();
		a = rand_bits(32);
		b = rand_bits(32);
		load_const(1, a);
		load_const(2, b);
		for (int i = 0; i < 8; i++) begin
			put(arith(ops[i], 3, 1, 2, 0, 1));
			put(mem_op(1, 0, 3, data_base + 4 * i));
		end
		put(halt_word());
		run_program("arith");
		for (int i = 0; i < 8; i++)
			check($sformatf("arith op %0d", ops[i]), alu_ref(ops[i], a, b),
				word_at(data_base + 4 * i));
	endtask

	task automatic test_imm();
		logic [15:0] imm;
		logic [15:0] hi;
		logic [31:0] a;
		prog.delete();
		// top bit forced so the immediate is negative
		imm = 16'(rand_bits(16)) | 16'h8000;
		hi = 16'(rand_bits(16));
		a = rand_bits(32);
		put(arith(opc_mov, 1, 0, 0, imm, 0));
		load_const(3, a);
		put(arith(opc_add, 4, 3, 0, imm, 0));
		put(arith(opc_movhi, 5, 0, 0, hi, 0));
		put(mem_op(1, 0, 1, data_base));
		put(mem_op(1, 0, 4, data_base + 4));
		put(mem_op(1, 0, 5, data_base + 8));
		put(halt_word());
		run_program("imm");
		check("imm mov", {16'hffff, imm}, word_at(data_base));
		check("imm add", a + {16'hffff, imm}, word_at(data_base + 4));
		check("imm movhi", {hi, 16'h0}, word_at(data_base + 8));
	endtask

	task automatic test_branch();
		logic [31:0] a [4];
		logic [31:0] b [4];
		logic [2:0] conds [4] = '{cond_eq, cond_ne, cond_lt, cond_ge};
		logic taken;
		logic [31:0] addr;
		prog.delete();
		load_const(4, marker);
		for (int p = 0; p < 4; p++) begin
			a[p] = rand_bits(32);
			// equal, one above, one below, then a free pair
			case (p)
			0: b[p] = a[p];
			1: b[p] = a[p] + 1;
			2: b[p] = a[p] - 1;
			default: b[p] = rand_bits(32);
			endcase
			load_const(1, a[p]);
			load_const(2, b[p]);
			put(arith(opc_cmp, 0, 1, 2, 0, 1));
			// a taken branch hops over the marker store
			for (int c = 0; c < 4; c++) begin
				put(branch(conds[c], 0, 0, 24'd1));
				put(mem_op(1, 0, 4, data_base + 16 * p + 4 * c));
			end
		end
		put(halt_word());
		run_program("branch");
		for (int p = 0; p < 4; p++) begin
			for (int c = 0; c < 4; c++) begin
				case (c)
				0: taken = a[p] == b[p];
				1: taken = a[p] != b[p];
				2: taken = a[p] < b[p];
				default: taken = a[p] >= b[p];
				endcase
				addr = data_base + 16 * p + 4 * c;
				check($sformatf("branch pair %0d cond %0d", p, c),
					taken ? fill_word(addr) : marker, word_at(addr));
			end
		end
	endtask

	task automatic test_jump();
		int base;
		logic [15:0] n;
		prog.delete();
		n = 16'(rand_bits(4) + 2);
		load_const(6, marker);
		base = prog.size();
		// target sits after the five constant words, the jump and the skipped store
		load_const(5, 32'(4 * (base + 7)));
		put(branch(cond_always, 1, 5, 0));
		put(mem_op(1, 0, 6, data_base));
		put(mem_op(1, 0, 6, data_base + 4));
		put(arith(opc_mov, 1, 0, 0, 0, 0));
		put(arith(opc_mov, 2, 0, 0, n, 0));
		// loop top exits on equal, otherwise counts and jumps back four words
		put(arith(opc_cmp, 0, 1, 2, 0, 1));
		put(branch(cond_eq, 0, 0, 24'd2));
		put(arith(opc_add, 1, 1, 0, 1, 0));
		put(branch(cond_always, 0, 0, 24'hfffffc));
		put(mem_op(1, 0, 1, data_base + 8));
		put(halt_word());
		run_program("jump");
		check("jump skipped store", fill_word(data_base), word_at(data_base));
		check("jump target store", marker, word_at(data_base + 4));
		check("loop count", {16'h0, n}, word_at(data_base + 8));
	endtask

	task automatic test_ldst();
		logic [31:0] vals [4];
		logic [31:0] addrs [4];
		prog.delete();
		// one random word per 256-byte slot keeps the addresses apart
		for (int i = 0; i < 4; i++) begin
			vals[i] = rand_bits(32);
			addrs[i] = data_base + 256 * i + {rand_bits(6), 2'b00};
			load_const(1, vals[i]);
			put(mem_op(1, 0, 1, addrs[i]));
		end
		for (int i = 0; i < 4; i++) begin
			put(mem_op(0, 2, 0, addrs[i]));
			put(mem_op(1, 0, 2, addrs[i] + 32'h1000));
		end
		put(halt_word());
		run_program("ldst");
		for (int i = 0; i < 4; i++) begin
			check($sformatf("ldst store %0d", i), vals[i], word_at(addrs[i]));
			check($sformatf("ldst copy %0d", i), vals[i], word_at(addrs[i] + 32'h1000));
		end
	endtask

	task automatic test_halt_reset();
		int cycles;
		prog.delete();
		// endless store loop keeps the data port busy when reset hits
		put(mem_op(1, 0, 0, data_base + 4));
		put(branch(cond_always, 0, 0, 24'hfffffe));
		start_program();
		cycles = 0;
		while (!dmem_wr_req.awvalid) begin
			if (cycles == run_limit) begin
				$display("reset: core issued no store within %0d cycles", run_limit);
				$display("sim failed");
				$fatal(1);
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		check("reset arvalid", 32'd0, 32'(imem_req.arvalid));
		check("reset rready", 32'd0, 32'(imem_req.rready | dmem_rd_req.rready));
		check("reset data arvalid", 32'd0, 32'(dmem_rd_req.arvalid));
		check("reset awvalid", 32'd0, 32'(dmem_wr_req.awvalid));
		check("reset wvalid", 32'd0, 32'(dmem_wr_req.wvalid));
		check("reset bready", 32'd0, 32'(dmem_wr_req.bready));
		prog.delete();
		// zero registers make the first store write zero over the fill
		put(mem_op(1, 0, 0, data_base));
		put(halt_word());
		run_program("halt");
		// halted holds and nothing more is fetched
		repeat (8) @(posedge clk);
		#1;
		check("halt sticky", 32'd1, 32'(halted));
		check("halt fetch idle", 32'd0, 32'(imem_req.arvalid));
		check("halt marker", 32'd0, word_at(data_base));
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		check("reset halted", 32'd0, 32'(halted));
		check("reset instr", 32'd0, dut.u_fetch.instr);
		// memory is refilled so the marker must be written again
		run_program("restart");
		check("restart marker", 32'd0, word_at(data_base));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// run
	// ~~~~~~~~~~~~~~~~~~~~

	initial begin
		#(num_tests * max_instr * 40 * 8);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$fatal(1);
	end

	initial begin
		reset = 1'b1;
		fill = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		lfsr = 32'hec22;
		test_arith();
		test_imm();
		test_branch();
		test_jump();
		test_ldst();
		test_halt_reset();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== sim/tb_mem.sv ====
// one read channel with a fixed delay before arready and again before rvalid
module axil_rd_port #(
	parameter int DELAY = 1
) (
	input  logic clk,
	input  logic reset,
	input  oldland_pipe_pkg::axil_rd_req_t req,
	input  logic [31:0] word,
	output oldland_pipe_pkg::axil_rd_rsp_t rsp,
	output logic [31:0] addr_q
);

	int cnt;
	logic busy;

	always @(posedge clk) begin
		if (reset) begin
			rsp <= '0;
			cnt <= 0;
			busy <= 1'b0;
			addr_q <= '0;
		end else begin
			rsp.arready <= 1'b0;
			if (!busy) begin
				if (req.arvalid) begin
					if (cnt == DELAY) begin
						rsp.arready <= 1'b1;
						addr_q <= req.araddr;
						busy <= 1'b1;
						cnt <= 0;
					end else begin
						cnt <= cnt + 1;
					end
				end
			end else if (!rsp.rvalid) begin
				// word follows addr_q one cycle after capture
				if (cnt == DELAY) begin
					rsp.rvalid <= 1'b1;
					rsp.rdata <= word;
					cnt <= 0;
				end else begin
					cnt <= cnt + 1;
				end
			end else if (req.rready) begin
				rsp.rvalid <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

endmodule

module tb_mem #(
	parameter int I_DELAY = 1,
	parameter int R_DELAY = 2,
	parameter int W_DELAY = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic fill,
	input  logic load_en,
	input  logic [11:0] load_addr,
	input  logic [31:0] load_data,
	input  oldland_pipe_pkg::axil_rd_req_t imem_req,
	input  oldland_pipe_pkg::axil_rd_req_t dmem_rd_req,
	input  oldland_pipe_pkg::axil_wr_req_t dmem_wr_req,
	output oldland_pipe_pkg::axil_rd_rsp_t imem_rsp,
	output oldland_pipe_pkg::axil_rd_rsp_t dmem_rd_rsp,
	output oldland_pipe_pkg::axil_wr_rsp_t dmem_wr_rsp
);

	// 16 KiB of words shared by both masters
	logic [31:0] words [4096];
	logic [31:0] i_addr;
	logic [31:0] d_addr;
	int wcnt;
	logic wbusy;

	axil_rd_port #(.DELAY(I_DELAY)) u_iport (
		.clk, .reset, .req(imem_req), .word(words[i_addr[13:2]]),
		.rsp(imem_rsp), .addr_q(i_addr)
	);

	axil_rd_port #(.DELAY(R_DELAY)) u_dport (
		.clk, .reset, .req(dmem_rd_req), .word(words[d_addr[13:2]]),
		.rsp(dmem_rd_rsp), .addr_q(d_addr)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// write side and loading
	// ~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		// fill word carries its own byte address in the low half
		if (fill) begin
			for (int i = 0; i < 4096; i++)
				words[i] <= {16'ha5a5, 16'(i * 4)};
		end else if (load_en) begin
			words[load_addr] <= load_data;
		end
		if (reset) begin
			dmem_wr_rsp <= '0;
			wcnt <= 0;
			wbusy <= 1'b0;
		end else begin
			dmem_wr_rsp.awready <= 1'b0;
			dmem_wr_rsp.wready <= 1'b0;
			if (!wbusy) begin
				// aw and w come together so accept both at once
				if (dmem_wr_req.awvalid && dmem_wr_req.wvalid) begin
					if (wcnt == W_DELAY) begin
						dmem_wr_rsp.awready <= 1'b1;
						dmem_wr_rsp.wready <= 1'b1;
						for (int b = 0; b < 4; b++)
							if (dmem_wr_req.wstrb[b])
								words[dmem_wr_req.awaddr[13:2]][8*b +: 8] <=
									dmem_wr_req.wdata[8*b +: 8];
						wbusy <= 1'b1;
						wcnt <= 0;
					end else begin
						wcnt <= wcnt + 1;
					end
				end
			end else if (!dmem_wr_rsp.bvalid) begin
				if (wcnt == W_DELAY) begin
					dmem_wr_rsp.bvalid <= 1'b1;
					wcnt <= 0;
				end else begin
					wcnt <= wcnt + 1;
				end
			end else if (dmem_wr_req.bready) begin
				dmem_wr_rsp.bvalid <= 1'b0;
				wbusy <= 1'b0;
			end
		end
	end

endmodule

// ==== source/oldland_cpu.sv ====
module oldland_cpu #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic clk,
	input  logic reset,
	input  oldland_pipe_pkg::axil_rd_rsp_t imem_rsp,
	input  oldland_pipe_pkg::axil_rd_rsp_t dmem_rd_rsp,
	input  oldland_pipe_pkg::axil_wr_rsp_t dmem_wr_rsp,
	output oldland_pipe_pkg::axil_rd_req_t imem_req,
	output oldland_pipe_pkg::axil_rd_req_t dmem_rd_req,
	output oldland_pipe_pkg::axil_wr_req_t dmem_wr_req,
	output logic halted
);
	import oldland_pipe_pkg::*;

	logic [31:0] instr;
	logic [31:0] pc;
	logic [2:0] ra_sel;
	logic [2:0] rb_sel;
	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] load_data;
	logic decode_en;
	logic exec_en;
	logic mem_start;
	logic mem_done;
	logic wb_en;
	logic is_mem;
	logic rf_wr_en;
	logic [31:0] rf_wr_data;
	decode_ctl_t ctl;
	exec_result_t result;

	assign is_mem = ctl.mem_load || ctl.mem_store;

	// writeback picks the lsu data for loads
	assign rf_wr_en = wb_en && (ctl.update_rd || ctl.mem_load);
	assign rf_wr_data = ctl.mem_load ? load_data : result.alu_result;

	oldland_fetch #(.RESET_PC(RESET_PC)) u_fetch (
		.clk, .reset, .imem_rsp,
		.halt_req(ctl.halt), .is_mem, .mem_done,
		.branch_taken(result.branch_taken), .branch_target(result.branch_target),
		.imem_req, .instr, .pc,
		.decode_en, .exec_en, .mem_start, .wb_en, .halted
	);

	oldland_decode u_decode (
		.clk, .instr, .decode_en, .ra_sel, .rb_sel, .ctl
	);

	oldland_regfile u_regfile (
		.clk, .reset, .ra_sel, .rb_sel,
		.wr_en(rf_wr_en), .wr_sel(ctl.rd_sel), .wr_data(rf_wr_data),
		.ra_data, .rb_data
	);

	oldland_exec u_exec (
		.clk, .reset, .exec_en, .ctl, .pc, .ra_data, .rb_data, .result
	);

	oldland_lsu u_lsu (
		.clk, .reset, .mem_start, .ctl, .result,
		.dmem_rd_rsp, .dmem_wr_rsp, .dmem_rd_req, .dmem_wr_req,
		.load_data, .mem_done
	);

endmodule

// ==== source/oldland_lsu.sv ====
module oldland_lsu (
	input  logic clk,
	input  logic reset,
	input  logic mem_start,
	input  oldland_pipe_pkg::decode_ctl_t ctl,
	input  oldland_pipe_pkg::exec_result_t result,
	input  oldland_pipe_pkg::axil_rd_rsp_t dmem_rd_rsp,
	input  oldland_pipe_pkg::axil_wr_rsp_t dmem_wr_rsp,
	output oldland_pipe_pkg::axil_rd_req_t dmem_rd_req,
	output oldland_pipe_pkg::axil_wr_req_t dmem_wr_req,
	output logic [31:0] load_data,
	output logic mem_done
);

	typedef enum logic [2:0] {
		lsu_idle,
		lsu_write,
		lsu_resp,
		lsu_addr,
		lsu_data
	} lsu_state_e;

	lsu_state_e state;
	// aw and w may complete in either order
	logic aw_done;
	logic w_done;
	logic aw_ok;
	logic w_ok;
	logic [31:0] addr_q;
	logic [31:0] wdata_q;

	// write side with whole words only
	assign dmem_wr_req.awaddr = addr_q;
	assign dmem_wr_req.awvalid = state == lsu_write && !aw_done;
	assign dmem_wr_req.wdata = wdata_q;
	assign dmem_wr_req.wstrb = 4'hf;
	assign dmem_wr_req.wvalid = state == lsu_write && !w_done;
	assign dmem_wr_req.bready = state == lsu_resp;

	// read side
	assign dmem_rd_req.araddr = addr_q;
	assign dmem_rd_req.arvalid = state == lsu_addr;
	assign dmem_rd_req.rready = state == lsu_data;

	assign aw_ok = aw_done || (dmem_wr_req.awvalid && dmem_wr_rsp.awready);
	assign w_ok = w_done || (dmem_wr_req.wvalid && dmem_wr_rsp.wready);

	// done on the last handshake of either access
	assign mem_done = (state == lsu_resp && dmem_wr_rsp.bvalid) ||
		(state == lsu_data && dmem_rd_rsp.rvalid);

	// payload captured at start and held through the access
	always_ff @(posedge clk) begin
		if (state == lsu_idle && mem_start) begin
			addr_q <= result.mem_addr;
			wdata_q <= result.store_data;
		end
		if (state == lsu_data && dmem_rd_rsp.rvalid)
			load_data <= dmem_rd_rsp.rdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lsu_idle;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			case (state)
			lsu_idle: begin
				aw_done <= 1'b0;
				w_done <= 1'b0;
				if (mem_start)
					state <= ctl.mem_store ? lsu_write : lsu_addr;
			end
			lsu_write: begin
				aw_done <= aw_ok;
				w_done <= w_ok;
				if (aw_ok && w_ok)
					state <= lsu_resp;
			end
			lsu_resp: if (dmem_wr_rsp.bvalid) state <= lsu_idle;
			lsu_addr: if (dmem_rd_rsp.arready) state <= lsu_data;
			lsu_data: if (dmem_rd_rsp.rvalid) state <= lsu_idle;
			default: state <= lsu_idle;
			endcase
		end
	end

endmodule

// ==== source/oldland_exec.sv ====
module oldland_exec (
	input  logic clk,
	input  logic reset,
	input  logic exec_en,
	input  oldland_pipe_pkg::decode_ctl_t ctl,
	input  logic [31:0] pc,
	input  logic [31:0] ra_data,
	input  logic [31:0] rb_data,
	output oldland_pipe_pkg::exec_result_t result
);
	import oldland_isa_pkg::*;

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] sum;
	logic [31:0] diff;
	logic [31:0] alu_out;
	logic [4:0] shamt;
	logic zero_flag;
	logic carry_flag;
	logic cond_met;

	// ~~~~~~~~~~~~~~~~~~~~
	// alu
	// ~~~~~~~~~~~~~~~~~~~~

	assign op1 = ctl.alu_op1_ra ? ra_data : 32'd0;
	assign op2 = ctl.alu_op2_rb ? rb_data : ctl.imm32;
	assign sum = op1 + op2;
	assign diff = op1 - op2;
	// shifts use the low five bits only
	assign shamt = op2[4:0];

	always_comb begin
		case (ctl.alu_opc)
		opc_add: alu_out = sum;
		opc_sub: alu_out = diff;
		opc_and: alu_out = op1 & op2;
		opc_or: alu_out = op1 | op2;
		opc_xor: alu_out = op1 ^ op2;
		opc_lsl: alu_out = op1 << shamt;
		opc_lsr: alu_out = op1 >> shamt;
		opc_asr: alu_out = $signed(op1) >>> shamt;
		// movhi already has its immediate shifted up by decode
		opc_mov, opc_movhi: alu_out = op2;
		opc_cmp: alu_out = diff;
		default: alu_out = sum;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// flags
	// ~~~~~~~~~~~~~~~~~~~~

	// only cmp touches the flags
	always_ff @(posedge clk) begin
		if (reset) begin
			zero_flag <= 1'b0;
			carry_flag <= 1'b0;
		end else if (exec_en && ctl.alu_opc == opc_cmp) begin
			zero_flag <= op1 == op2;
			// unsigned borrow
			carry_flag <= op1 < op2;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// branch
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (ctl.branch_condition)
		cond_always: cond_met = 1'b1;
		cond_eq: cond_met = zero_flag;
		cond_ne: cond_met = !zero_flag;
		cond_lt: cond_met = carry_flag;
		cond_ge: cond_met = !carry_flag;
		default: cond_met = 1'b0;
		endcase
	end

	assign result.alu_result = alu_out;
	// loads and stores run the alu as ra plus imm
	assign result.mem_addr = sum;
	assign result.store_data = rb_data;
	assign result.branch_taken = ctl.is_branch && cond_met;
	// offset counts from the following instruction
	assign result.branch_target = ctl.branch_ra ? ra_data : pc + 32'd4 + ctl.imm32;

endmodule

// ==== source/oldland_regfile.sv ====
module oldland_regfile (
	input  logic clk,
	input  logic reset,
	input  logic [2:0] ra_sel,
	input  logic [2:0] rb_sel,
	input  logic wr_en,
	input  logic [2:0] wr_sel,
	input  logic [31:0] wr_data,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data
);

	logic [31:0] regs [8];

	// reads straight out of the array
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

// ==== source/oldland_decode.sv ====
module oldland_decode (
	input  logic clk,
	input  logic [31:0] instr,
	input  logic decode_en,
	output logic [2:0] ra_sel,
	output logic [2:0] rb_sel,
	output oldland_pipe_pkg::decode_ctl_t ctl
);
	import oldland_isa_pkg::*;

	instr_class_e iclass;
	logic [3:0] opcode;
	logic [31:0] imm16;
	logic [31:0] imm24;

	assign iclass = instr_class_e'(instr[class_msb:class_lsb]);
	assign opcode = instr[opc_msb:opc_lsb];

	// sign extended immediates
	assign imm16 = {{16{instr[imm16_msb]}}, instr[imm16_msb:imm16_lsb]};
	// branch offset counts words
	assign imm24 = {{6{instr[imm24_msb]}}, instr[imm24_msb:imm24_lsb], 2'b00};

	// register selects leave combinationally
	// so the register file read lands in this same cycle
	assign ra_sel = instr[ra_msb:ra_lsb];
	assign rb_sel = instr[rb_msb:rb_lsb];

	always_ff @(posedge clk) begin
		if (decode_en) begin
			ctl.rd_sel <= instr[rd_msb:rd_lsb];
			// non-arith classes run the alu as an adder
			ctl.alu_opc <= iclass == class_arith ? alu_opcode_e'(opcode) : opc_add;
			// cmp only sets flags and loads write rd from the lsu
			ctl.update_rd <= iclass == class_arith && opcode != opc_cmp;
			ctl.branch_condition <= branch_cond_e'(instr[cond_msb:cond_lsb]);

			// movhi puts its immediate in the upper half
			if (iclass == class_branch)
				ctl.imm32 <= imm24;
			else if (iclass == class_arith && opcode == opc_movhi)
				ctl.imm32 <= {instr[imm16_msb:imm16_lsb], 16'b0};
			else
				ctl.imm32 <= imm16;

			ctl.is_branch <= iclass == class_branch;
			ctl.branch_ra <= iclass == class_branch && instr[branch_ra_bit];

			// mem class adds ra and the immediate for the address
			ctl.alu_op1_ra <= iclass == class_arith || iclass == class_mem;
			ctl.alu_op2_rb <= iclass == class_arith && instr[op2_rb_bit];

			ctl.mem_load <= iclass == class_mem && !instr[store_bit];
			ctl.mem_store <= iclass == class_mem && instr[store_bit];

			ctl.halt <= iclass == class_misc && opcode == misc_halt;
		end
	end

endmodule

// ==== source/oldland_fetch.sv ====
module oldland_fetch #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic clk,
	input  logic reset,
	input  oldland_pipe_pkg::axil_rd_rsp_t imem_rsp,
	input  logic halt_req,
	input  logic is_mem,
	input  logic mem_done,
	input  logic branch_taken,
	input  logic [31:0] branch_target,
	output oldland_pipe_pkg::axil_rd_req_t imem_req,
	output logic [31:0] instr,
	output logic [31:0] pc,
	output logic decode_en,
	output logic exec_en,
	output logic mem_start,
	output logic wb_en,
	output logic halted
);

	// one instruction at a time through these states
	typedef enum logic [2:0] {
		seq_start,
		seq_fetch_addr,
		seq_fetch_data,
		seq_decode,
		seq_execute,
		seq_memory,
		seq_writeback,
		seq_halted
	} seq_state_e;

	seq_state_e state;

	// instruction read straight from the state
	// the pc is the address and stays put until writeback
	assign imem_req.araddr = pc;
	assign imem_req.arvalid = state == seq_fetch_addr;
	assign imem_req.rready = state == seq_fetch_data;

	// per state enables
	assign decode_en = state == seq_decode;
	assign exec_en = state == seq_execute;
	// single cycle since execute lasts one cycle
	assign mem_start = state == seq_execute && is_mem && !halt_req;
	assign wb_en = state == seq_writeback;
	assign halted = state == seq_halted;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seq_start;
			pc <= RESET_PC;
			instr <= '0;
		end else begin
			case (state)
			seq_start: state <= seq_fetch_addr;
			seq_fetch_addr: if (imem_rsp.arready) state <= seq_fetch_data;
			seq_fetch_data: begin
				if (imem_rsp.rvalid) begin
					instr <= imem_rsp.rdata;
					state <= seq_decode;
				end
			end
			seq_decode: state <= seq_execute;
			seq_execute: begin
				// halt skips writeback so the pc stays on the halt
				if (halt_req)
					state <= seq_halted;
				else if (is_mem)
					state <= seq_memory;
				else
					state <= seq_writeback;
			end
			seq_memory: if (mem_done) state <= seq_writeback;
			seq_writeback: begin
				pc <= branch_taken ? branch_target : pc + 32'd4;
				state <= seq_fetch_addr;
			end
			// sticky until reset
			seq_halted: state <= seq_halted;
			default: state <= seq_start;
			endcase
		end
	end

endmodule

// ==== source/oldland_pipe_pkg.sv ====
package oldland_pipe_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// stage bundles
	// ~~~~~~~~~~~~~~~~~~~~

	// decode output held for execute memory and writeback
	typedef struct packed {
		logic [2:0] rd_sel;
		logic update_rd;
		logic [31:0] imm32;
		oldland_isa_pkg::alu_opcode_e alu_opc;
		oldland_isa_pkg::branch_cond_e branch_condition;
		logic is_branch;
		logic branch_ra;
		logic alu_op1_ra;
		logic alu_op2_rb;
		logic mem_load;
		logic mem_store;
		logic halt;
	} decode_ctl_t;

	// execute output
	typedef struct packed {
		logic [31:0] alu_result;
		logic [31:0] mem_addr;
		logic [31:0] store_data;
		logic branch_taken;
		logic [31:0] branch_target;
	} exec_result_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// axi4-lite channels
	// ~~~~~~~~~~~~~~~~~~~~

	// master to slave read side
	typedef struct packed {
		logic [31:0] araddr;
		logic arvalid;
		logic rready;
	} axil_rd_req_t;

	// slave to master read side
	typedef struct packed {
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rd_rsp_t;

	// master to slave write side
	typedef struct packed {
		logic [31:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
	} axil_wr_req_t;

	// slave to master write side
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
	} axil_wr_rsp_t;

endpackage

// ==== source/oldland_isa_pkg.sv ====
package oldland_isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// encodings
	// ~~~~~~~~~~~~~~~~~~~~

	// top two bits of every instruction word
	typedef enum logic [1:0] {
		class_arith  = 2'd0,
		class_branch = 2'd1,
		class_mem    = 2'd2,
		class_misc   = 2'd3
	} instr_class_e;

	// arithmetic opcode field
	typedef enum logic [3:0] {
		opc_add   = 4'h0,
		opc_sub   = 4'h1,
		opc_and   = 4'h2,
		opc_or    = 4'h3,
		opc_xor   = 4'h4,
		opc_lsl   = 4'h5,
		opc_lsr   = 4'h6,
		opc_asr   = 4'h7,
		opc_mov   = 4'h8,
		opc_movhi = 4'h9,
		opc_cmp   = 4'ha
	} alu_opcode_e;

	// misc class reuses the opcode field
	localparam logic [3:0] misc_halt = 4'h0;

	// lt and ge look only at carry so they are unsigned
	typedef enum logic [2:0] {
		cond_always = 3'd0,
		cond_eq     = 3'd1,
		cond_ne     = 3'd2,
		cond_lt     = 3'd3,
		cond_ge     = 3'd4
	} branch_cond_e;

	// ~~~~~~~~~~~~~~~~~~~~
	// field positions
	// ~~~~~~~~~~~~~~~~~~~~

	localparam int class_msb = 31;
	localparam int class_lsb = 30;
	localparam int opc_msb = 29;
	localparam int opc_lsb = 26;
	localparam int cond_msb = 28;
	localparam int cond_lsb = 26;
	// set for a store in the mem class
	localparam int store_bit = 28;
	// branch through ra instead of the pc relative offset
	localparam int branch_ra_bit = 25;
	localparam int imm16_msb = 25;
	localparam int imm16_lsb = 10;
	// second operand from rb instead of the immediate
	localparam int op2_rb_bit = 9;
	localparam int rd_msb = 8;
	localparam int rd_lsb = 6;
	localparam int ra_msb = 5;
	localparam int ra_lsb = 3;
	localparam int rb_msb = 2;
	localparam int rb_lsb = 0;
	// branch offset in words
	localparam int imm24_msb = 23;
	localparam int imm24_lsb = 0;

endpackage
